/* build.f */
hdl/rv_decode_pkg.sv
hdl/imm_gen.sv
hdl/inst_classify.sv
hdl/reg_access.sv
hdl/rv_decode_top.sv
dv/tb_clkgen.sv
dv/rv_decode_assertions.sv
dv/rv_decode_tb.sv

/* Makefile */
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -Wno-fatal
TOP        ?= rv_decode_tb
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
SIM_ARGS   ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "run failed"; exit 1; \
	fi
	@if ! grep -q "Simulation PASSED" $(LOG); then \
		echo "run ended without a verdict"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/rv_decode_tb.sv */
// decode stage testbench
`timescale 1ns/1ps

module rv_decode_tb import rv_decode_pkg::*; ();

    localparam int TIMEOUT = 50;

    logic            clk;
    logic            rst_n;
    logic            inst_valid;
    inst_t           inst;
    logic [XLEN-1:0] inst_addr;
    logic            dec_valid;
    dec_out_t        dec;
    int              pass_cnt;
    int              fail_cnt;
    int              err_before;
    logic            timed_out;
    logic [31:0]     r;

    tb_clkgen u_clkgen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    rv_decode_top u_dut (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .inst_valid_i (inst_valid),
        .inst_i       (inst),
        .inst_addr_i  (inst_addr),
        .dec_valid_o  (dec_valid),
        .dec_o        (dec)
    );

    // random registers around the given opcode and funct fields
    function automatic logic [31:0] make_inst(logic [6:0] opc, logic [2:0] f3, logic [6:0] f7);
        logic [31:0] v;
        v = $urandom();
        return {f7, v[24:15], f3, v[11:7], opc};
    endfunction

    function automatic logic [6:0] pick_opcode(int k);
        case (k)
            0: return OPC_LUI;
            1: return OPC_AUIPC;
            2: return OPC_JAL;
            3: return OPC_JALR;
            4: return OPC_BRANCH;
            5: return OPC_LOAD;
            6: return OPC_STORE;
            7: return OPC_OP_IMM;
            8: return OPC_OP;
            9: return OPC_MISC_MEM;
            default: return OPC_SYSTEM;
        endcase
    endfunction

    // called at a falling edge, returns at the falling edge that shows the result
    task automatic issue(input logic [31:0] word);
        int n;
        inst_valid = 1'b1;
        inst       = word;
        inst_addr  = $urandom();
        @(negedge clk);
        n = 1;
        while (!dec_valid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!dec_valid) begin
            $display("timeout: dec_valid_o never rose for instruction %h", word);
            timed_out = 1'b1;
        end
    endtask

    task automatic bubble();
        inst_valid = 1'b0;
        inst       = $urandom();
        @(negedge clk);
        @(negedge clk);
    endtask

    task automatic report_test(input string name);
        int n;
        n = u_dut.u_assertions.fail_count - err_before;
        if (n != 0) begin
            $display("mismatch %s: expected 0 assertion failures, actual %0d", name, n);
            fail_cnt++;
        end else if (timed_out) begin
            $display("test %s failed because a wait timed out", name);
            fail_cnt++;
        end else begin
            $display("test %s passed", name);
            pass_cnt++;
        end
        err_before = u_dut.u_assertions.fail_count;
        timed_out  = 1'b0;
    endtask

    initial begin
        int n;
        inst_valid = 1'b1;
        inst       = INST_ECALL;
        inst_addr  = '0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        err_before = 0;
        timed_out  = 1'b0;
        void'($urandom(32'h2fbc));

        // reset, with a valid input held during reset
        n = 0;
        while (rst_n !== 1'b1 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("timeout: reset was never released");
            timed_out = 1'b1;
        end
        bubble();
        issue(INST_NOP);
        bubble();
        report_test("reset");

        issue(make_inst(OPC_LUI, 3'($urandom()), 7'($urandom())));
        issue(make_inst(OPC_AUIPC, 3'($urandom()), 7'($urandom())));
        for (int f = 0; f < 8; f++) begin
            issue(make_inst(OPC_OP_IMM, 3'(f), F7_BASE));
            issue(make_inst(OPC_OP_IMM, 3'(f), F7_ALT));
            issue(make_inst(OPC_OP_IMM, 3'(f), F7_MULDIV));
            issue(make_inst(OPC_OP, 3'(f), F7_BASE));
            issue(make_inst(OPC_OP, 3'(f), F7_ALT));
        end
        bubble();
        report_test("alu");

        issue(make_inst(OPC_JAL, 3'($urandom()), 7'($urandom())));
        for (int f = 0; f < 8; f++) begin
            issue(make_inst(OPC_JALR, 3'(f), 7'($urandom())));
            issue(make_inst(OPC_BRANCH, 3'(f), 7'($urandom())));
        end
        bubble();
        report_test("bjp");

        for (int f = 0; f < 8; f++) begin
            issue(make_inst(OPC_LOAD, 3'(f), 7'($urandom())));
            issue(make_inst(OPC_STORE, 3'(f), 7'($urandom())));
        end
        bubble();
        report_test("mem");

        for (int f = 0; f < 8; f++) begin
            issue(make_inst(OPC_OP, 3'(f), F7_MULDIV));
            issue(make_inst(OPC_MISC_MEM, 3'(f), 7'($urandom())));
        end
        issue(INST_NOP);
        issue(INST_ECALL);
        issue(INST_EBREAK);
        issue(INST_MRET);
        issue(INST_DRET);
        issue(make_inst(OPC_SYSTEM, 3'($urandom()), 7'($urandom())));
        bubble();
        report_test("muldiv_sys");

        for (int i = 0; i < 200; i++) begin
            r = $urandom();
            if (r[0])
                issue($urandom());
            else
                issue(make_inst(pick_opcode(int'(r[8:1]) % 11), r[11:9], r[18:12]));
            if (i % 17 == 0)
                bubble();
        end
        bubble();
        report_test("random");

        $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* dv/rv_decode_assertions.sv */
// decode stage checks
`timescale 1ns/1ps

module rv_decode_assertions import rv_decode_pkg::*; (
    input logic            clk,
    input logic            rst_n_i,
    input logic            inst_valid_i,
    input inst_t           inst_i,
    input logic [XLEN-1:0] inst_addr_i,
    input logic            dec_valid_o,
    input dec_out_t        dec_o
);

    int              fail_count = 0;
    logic            seen = 1'b0;
    logic            p_rst;
    logic            p_valid;
    inst_t           p_inst;
    logic [XLEN-1:0] p_addr;
    logic            chk;

    // inputs seen at the previous rising edge
    always_ff @(posedge clk) begin
        seen    <= 1'b1;
        p_rst   <= rst_n_i;
        p_valid <= inst_valid_i;
        p_inst  <= inst_i;
        p_addr  <= inst_addr_i;
    end

    assign chk = seen && p_rst && p_valid;

    function automatic dec_grp_e exp_grp(inst_t i);
        dec_grp_e g;
        g = GRP_NONE;
        case (i.opcode)
            OPC_LUI, OPC_AUIPC, OPC_JAL: g = (i.opcode == OPC_JAL) ? GRP_BJP : GRP_ALU;
            OPC_JALR:   if (i.funct3 == 3'd0) g = GRP_BJP;
            OPC_BRANCH: if (i.funct3 != 3'd2 && i.funct3 != 3'd3) g = GRP_BJP;
            OPC_LOAD:   if (i.funct3 != 3'd3 && i.funct3 < 3'd6) g = GRP_MEM;
            OPC_STORE:  if (i.funct3 < 3'd3) g = GRP_MEM;
            OPC_MISC_MEM: if (i.funct3 < 3'd2) g = GRP_SYS;
            OPC_SYSTEM: begin
                if (i == INST_ECALL || i == INST_EBREAK || i == INST_MRET || i == INST_DRET)
                    g = GRP_SYS;
            end
            OPC_OP_IMM: begin
                if (i == INST_NOP) g = GRP_SYS;
                else if (i.funct3 == 3'd1) g = (i.funct7 == F7_BASE) ? GRP_ALU : GRP_NONE;
                else if (i.funct3 == 3'd5)
                    g = (i.funct7 == F7_BASE || i.funct7 == F7_ALT) ? GRP_ALU : GRP_NONE;
                else g = GRP_ALU;
            end
            OPC_OP: begin
                if (i.funct7 == F7_BASE) g = GRP_ALU;
                else if (i.funct7 == F7_MULDIV) g = GRP_MULDIV;
                else if (i.funct7 == F7_ALT && (i.funct3 == 3'd0 || i.funct3 == 3'd5))
                    g = GRP_ALU;
            end
            default: g = GRP_NONE;
        endcase
        return g;
    endfunction

    function automatic logic [XLEN-1:0] exp_imm(inst_t i);
        logic [31:0] w;
        logic [XLEN-1:0] v;
        w = i;
        v = '0;
        case (i.opcode)
            OPC_LUI, OPC_AUIPC: v = {w[31:12], 12'b0};
            OPC_JAL:    v = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            OPC_JALR:   if (i.funct3 == 3'd0) v = {{20{w[31]}}, w[31:20]};
            OPC_LOAD:   v = {{20{w[31]}}, w[31:20]};
            OPC_BRANCH: v = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            OPC_STORE:  v = {{20{w[31]}}, w[31:25], w[11:7]};
            OPC_OP_IMM: begin
                if (i.funct3 == 3'd1) v = (i.funct7 == F7_BASE) ? {27'b0, w[24:20]} : '0;
                else if (i.funct3 == 3'd5)
                    v = (i.funct7 == F7_BASE || i.funct7 == F7_ALT) ? {27'b0, w[24:20]} : '0;
                else v = {{20{w[31]}}, w[31:20]};
            end
            default: v = '0;
        endcase
        return v;
    endfunction

    function automatic reg_ctrl_t exp_regs(inst_t i);
        reg_ctrl_t r;
        logic a1;
        logic a2;
        logic wr;
        a1 = !(i.opcode == OPC_LUI || i.opcode == OPC_AUIPC || i.opcode == OPC_JAL) &&
             (exp_grp(i) != GRP_SYS);
        a2 = (i.opcode == OPC_OP || i.opcode == OPC_STORE || i.opcode == OPC_BRANCH);
        wr = (i.opcode == OPC_LUI || i.opcode == OPC_AUIPC || i.opcode == OPC_JAL ||
              (i.opcode == OPC_JALR && i.funct3 == 3'd0) || i.opcode == OPC_LOAD ||
              (i.opcode == OPC_OP_IMM && i != INST_NOP) || i.opcode == OPC_OP) && (i.rd != 0);
        r.rs1_re   = a1 && (i.rs1 != 0);
        r.rs1_addr = a1 ? i.rs1 : '0;
        r.rs2_re   = a2 && (i.rs2 != 0);
        r.rs2_addr = a2 ? i.rs2 : '0;
        r.rd_we    = wr;
        r.rd_addr  = wr ? i.rd : '0;
        return r;
    endfunction

    function automatic logic exp_illegal(inst_t i);
        return (exp_grp(i) == GRP_NONE) ||
               (i.opcode == OPC_OP_IMM && i.funct3 == 3'd1 && i.funct7 == F7_MULDIV);
    endfunction

    // the flag that names the instruction must be set, and only that one
    function automatic logic key_ok(inst_t i, dec_info_t d);
        alu_info_t    a;
        bjp_info_t    b;
        mem_info_t    m;
        muldiv_info_t x;
        sys_info_t    s;
        logic [7:0]   oh;
        logic         sub_e;
        logic         sra_e;
        logic         ok;
        a     = d.payload.alu;
        b     = d.payload.bjp;
        m     = d.payload.mem;
        x     = d.payload.muldiv;
        s     = d.payload.sys;
        // funct3 as a one-hot, first table entry in the top bit
        oh    = 8'b1000_0000 >> i.funct3;
        sub_e = (i.opcode == OPC_OP) && (i.funct7 == F7_ALT) && (i.funct3 == 3'd0);
        sra_e = (i.funct7 == F7_ALT) && (i.funct3 == 3'd5);
        case (exp_grp(i))
            GRP_ALU: begin
                if (i.opcode == OPC_LUI)
                    ok = a.lui;
                else if (i.opcode == OPC_AUIPC)
                    ok = a.auipc && a.op1pc;
                else
                    ok = ({a.add, a.sll, a.slt, a.sltu, a.xor_, a.srl, a.or_, a.and_} ==
                          (oh & ~{sub_e, 4'b0, sra_e, 2'b0})) &&
                         (a.sub == sub_e) && (a.sra == sra_e) &&
                         (a.op2imm == (i.opcode == OPC_OP_IMM));
            end
            GRP_BJP: begin
                if (i.opcode == OPC_BRANCH)
                    ok = ({b.beq, b.bne, 2'b0, b.blt, b.bge, b.bltu, b.bgeu} == oh) && !b.jump;
                else
                    ok = b.jump && (b.op1rs1 == (i.opcode == OPC_JALR));
            end
            GRP_MEM: begin
                if (i.opcode == OPC_LOAD)
                    ok = ({m.lb, m.lh, m.lw, 1'b0, m.lbu, m.lhu, 2'b0} == oh) &&
                         m.op_load && !m.op_store;
                else
                    ok = ({m.sb, m.sh, m.sw, 5'b0} == oh) && m.op_store && !m.op_load;
            end
            GRP_MULDIV: begin
                ok = ({x.mul, x.mulh, x.mulhsu, x.mulhu, x.div, x.divu, x.rem, x.remu} == oh) &&
                     (x.op_mul == (i.funct3 < 3'd4)) && (x.op_div == (i.funct3 >= 3'd4));
            end
            GRP_SYS: begin
                ok = ({s.ecall, s.ebreak, s.nop, s.mret, s.dret, s.fence} ==
                      {i == INST_ECALL, i == INST_EBREAK, i == INST_NOP, i == INST_MRET,
                       i == INST_DRET, i.opcode == OPC_MISC_MEM});
            end
            default: ok = 1'b1;
        endcase
        return ok;
    endfunction

    a_reset: assert property (@(posedge clk) (seen && !p_rst) |-> (!dec_valid_o && dec_o == '0))
        else begin $error("outputs not cleared by reset"); fail_count++; end
    a_valid: assert property (@(posedge clk) (seen && p_rst) |-> (dec_valid_o == p_valid))
        else begin $error("dec_valid_o does not follow inst_valid_i"); fail_count++; end
    a_bubble: assert property (@(posedge clk) (seen && p_rst && !p_valid) |-> (dec_o == '0))
        else begin $error("bubble result not zero"); fail_count++; end
    a_addr: assert property (@(posedge clk) chk |-> (dec_o.inst_addr == p_addr))
        else begin $error("inst_addr wrong"); fail_count++; end
    a_imm: assert property (@(posedge clk) chk |-> (dec_o.imm == exp_imm(p_inst)))
        else begin $error("immediate wrong for %h", p_inst); fail_count++; end
    a_grp: assert property (@(posedge clk) chk |-> (dec_o.info.grp == exp_grp(p_inst)))
        else begin $error("group wrong for %h", p_inst); fail_count++; end
    a_payload: assert property (@(posedge clk) chk |-> key_ok(p_inst, dec_o.info))
        else begin $error("payload flag wrong for %h", p_inst); fail_count++; end
    a_regs: assert property (@(posedge clk) chk |-> (dec_o.regs == exp_regs(p_inst)))
        else begin $error("register control wrong for %h", p_inst); fail_count++; end
    a_illegal: assert property (@(posedge clk) chk |-> (dec_o.illegal == exp_illegal(p_inst)))
        else begin $error("illegal flag wrong for %h", p_inst); fail_count++; end

endmodule

bind rv_decode_top rv_decode_assertions u_assertions (.*);

/* dv/tb_clkgen.sv */
// testbench clock and reset
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        // hold reset for 10 cycles, release away from the rising edge
        repeat (10) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

    always #20 clk_o = ~clk_o;

endmodule

/* hdl/rv_decode_top.sv */
// decode stage top level
`timescale 1ns/1ps

module rv_decode_top import rv_decode_pkg::*; (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            inst_valid_i,
    input  inst_t           inst_i,
    input  logic [XLEN-1:0] inst_addr_i,
    output logic            dec_valid_o,
    output dec_out_t        dec_o
);

    logic [XLEN-1:0] imm;
    dec_info_t       info;
    logic            illegal;
    reg_ctrl_t       regs;
    dec_out_t        dec_d;

    imm_gen u_imm_gen (
        .inst_i (inst_i),
        .imm_o  (imm)
    );

    inst_classify u_inst_classify (
        .inst_i    (inst_i),
        .info_o    (info),
        .illegal_o (illegal)
    );

    // system ops touch no GPR, so the group feeds the rs1 rule
    reg_access u_reg_access (
        .inst_i (inst_i),
        .grp_i  (info.grp),
        .regs_o (regs)
    );

    always_comb begin
        dec_d.inst_addr = inst_addr_i;
        dec_d.imm       = imm;
        dec_d.info      = info;
        dec_d.regs      = regs;
        dec_d.illegal   = illegal;
    end

    // one-cycle output stage, bubbles leave an all-zero result
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            dec_valid_o <= 1'b0;
            dec_o       <= '0;
        end else begin
            dec_valid_o <= inst_valid_i;
            if (inst_valid_i) begin
                dec_o <= dec_d;
            end else begin
                dec_o <= '0;
            end
        end
    end

endmodule

/* hdl/reg_access.sv */
// register file access control
`timescale 1ns/1ps

module reg_access import rv_decode_pkg::*; (
    input  inst_t     inst_i,
    input  dec_grp_e  grp_i,
    output reg_ctrl_t regs_o
);

    logic no_rs1;
    logic acc_rs1;
    logic acc_rs2;
    logic writes_rd;
    logic wr_rd;

    // upper-immediate ops and jal take no source register
    assign no_rs1  = (inst_i.opcode == OPC_LUI) |
                     (inst_i.opcode == OPC_AUIPC) |
                     (inst_i.opcode == OPC_JAL);
    assign acc_rs1 = ~no_rs1 & (grp_i != GRP_SYS);

    assign acc_rs2 = (inst_i.opcode == OPC_OP) |
                     (inst_i.opcode == OPC_STORE) |
                     (inst_i.opcode == OPC_BRANCH);

    assign writes_rd = (inst_i.opcode == OPC_LUI) |
                       (inst_i.opcode == OPC_AUIPC) |
                       (inst_i.opcode == OPC_JAL) |
                       ((inst_i.opcode == OPC_JALR) & (inst_i.funct3 == 3'b000)) |
                       (inst_i.opcode == OPC_LOAD) |
                       ((inst_i.opcode == OPC_OP_IMM) & (inst_i != INST_NOP)) |
                       (inst_i.opcode == OPC_OP);

    // x0 is never written
    assign wr_rd = writes_rd & (inst_i.rd != '0);

    always_comb begin
        regs_o.rs1_re   = acc_rs1 & (inst_i.rs1 != '0);
        regs_o.rs1_addr = acc_rs1 ? inst_i.rs1 : '0;
        regs_o.rs2_re   = acc_rs2 & (inst_i.rs2 != '0);
        regs_o.rs2_addr = acc_rs2 ? inst_i.rs2 : '0;
        regs_o.rd_we    = wr_rd;
        regs_o.rd_addr  = wr_rd ? inst_i.rd : '0;
    end

endmodule

/* hdl/inst_classify.sv */
// instruction classifier
`timescale 1ns/1ps

module inst_classify import rv_decode_pkg::*; (
    input  inst_t     inst_i,
    output dec_info_t info_o,
    output logic      illegal_o
);

    logic         op_lui;
    logic         op_auipc;
    logic         op_jal;
    logic         op_jalr;
    logic         op_branch;
    logic         op_load;
    logic         op_store;
    logic         op_imm;
    logic         op_reg;
    logic         op_misc;
    logic [7:0]   f3;
    logic         f7_base;
    logic         f7_alt;
    logic         f7_muldiv;
    logic         is_nop;
    alu_info_t    alu;
    bjp_info_t    bjp;
    mem_info_t    mem;
    muldiv_info_t md;
    sys_info_t    sys;
    logic         hit_alu;
    logic         hit_bjp;
    logic         hit_mem;
    logic         hit_md;
    logic         hit_sys;
    logic         slli_bad;

    assign op_lui    = (inst_i.opcode == OPC_LUI);
    assign op_auipc  = (inst_i.opcode == OPC_AUIPC);
    assign op_jal    = (inst_i.opcode == OPC_JAL);
    assign op_jalr   = (inst_i.opcode == OPC_JALR);
    assign op_branch = (inst_i.opcode == OPC_BRANCH);
    assign op_load   = (inst_i.opcode == OPC_LOAD);
    assign op_store  = (inst_i.opcode == OPC_STORE);
    assign op_imm    = (inst_i.opcode == OPC_OP_IMM);
    assign op_reg    = (inst_i.opcode == OPC_OP);
    assign op_misc   = (inst_i.opcode == OPC_MISC_MEM);

    // one-hot funct3
    assign f3        = 8'b1 << inst_i.funct3;
    assign f7_base   = (inst_i.funct7 == F7_BASE);
    assign f7_alt    = (inst_i.funct7 == F7_ALT);
    assign f7_muldiv = (inst_i.funct7 == F7_MULDIV);
    assign is_nop    = (inst_i == INST_NOP);

    // nop is addi x0,x0,0 but belongs to the system group
    always_comb begin
        alu        = '0;
        alu.lui    = op_lui;
        alu.auipc  = op_auipc;
        alu.add    = (op_imm & f3[0] & ~is_nop) | (op_reg & f3[0] & f7_base);
        alu.sub    = op_reg & f3[0] & f7_alt;
        alu.sll    = (op_imm | op_reg) & f3[1] & f7_base;
        alu.slt    = (op_imm & f3[2]) | (op_reg & f3[2] & f7_base);
        alu.sltu   = (op_imm & f3[3]) | (op_reg & f3[3] & f7_base);
        alu.xor_   = (op_imm & f3[4]) | (op_reg & f3[4] & f7_base);
        alu.srl    = (op_imm | op_reg) & f3[5] & f7_base;
        alu.sra    = (op_imm | op_reg) & f3[5] & f7_alt;
        alu.or_    = (op_imm & f3[6]) | (op_reg & f3[6] & f7_base);
        alu.and_   = (op_imm & f3[7]) | (op_reg & f3[7] & f7_base);
        alu.op2imm = op_imm | op_lui | op_auipc;
        alu.op1pc  = op_auipc;
    end

    always_comb begin
        bjp        = '0;
        bjp.jump   = op_jal | (op_jalr & f3[0]);
        bjp.beq    = op_branch & f3[0];
        bjp.bne    = op_branch & f3[1];
        bjp.blt    = op_branch & f3[4];
        bjp.bge    = op_branch & f3[5];
        bjp.bltu   = op_branch & f3[6];
        bjp.bgeu   = op_branch & f3[7];
        // jalr takes its base from rs1, jal from pc
        bjp.op1rs1 = op_jalr & f3[0];
    end

    always_comb begin
        mem          = '0;
        mem.lb       = op_load & f3[0];
        mem.lh       = op_load & f3[1];
        mem.lw       = op_load & f3[2];
        mem.lbu      = op_load & f3[4];
        mem.lhu      = op_load & f3[5];
        mem.sb       = op_store & f3[0];
        mem.sh       = op_store & f3[1];
        mem.sw       = op_store & f3[2];
        mem.op_load  = op_load;
        mem.op_store = op_store;
    end

    always_comb begin
        md        = '0;
        md.mul    = op_reg & f7_muldiv & f3[0];
        md.mulh   = op_reg & f7_muldiv & f3[1];
        md.mulhsu = op_reg & f7_muldiv & f3[2];
        md.mulhu  = op_reg & f7_muldiv & f3[3];
        md.div    = op_reg & f7_muldiv & f3[4];
        md.divu   = op_reg & f7_muldiv & f3[5];
        md.rem    = op_reg & f7_muldiv & f3[6];
        md.remu   = op_reg & f7_muldiv & f3[7];
        md.op_mul = op_reg & f7_muldiv & ~inst_i.funct3[2];
        md.op_div = op_reg & f7_muldiv & inst_i.funct3[2];
    end

    always_comb begin
        sys        = '0;
        sys.ecall  = (inst_i == INST_ECALL);
        sys.ebreak = (inst_i == INST_EBREAK);
        sys.nop    = is_nop;
        sys.mret   = (inst_i == INST_MRET);
        sys.dret   = (inst_i == INST_DRET);
        sys.fence  = op_misc & (f3[0] | f3[1]);
    end

    // op2imm and op1pc are qualifiers, not instructions
    assign hit_alu = |{alu.lui, alu.auipc, alu.add, alu.sub, alu.sll, alu.slt, alu.sltu,
                       alu.xor_, alu.srl, alu.sra, alu.or_, alu.and_};
    assign hit_bjp = |{bjp.jump, bjp.beq, bjp.bne, bjp.blt, bjp.bge, bjp.bltu, bjp.bgeu};
    assign hit_mem = |{mem.lb, mem.lh, mem.lw, mem.lbu, mem.lhu, mem.sb, mem.sh, mem.sw};
    assign hit_md  = md.op_mul | md.op_div;
    assign hit_sys = |{sys.ecall, sys.ebreak, sys.nop, sys.mret, sys.dret, sys.fence};

    always_comb begin
        if (hit_alu) begin
            info_o.grp = GRP_ALU;
        end else if (hit_bjp) begin
            info_o.grp = GRP_BJP;
        end else if (hit_mem) begin
            info_o.grp = GRP_MEM;
        end else if (hit_md) begin
            info_o.grp = GRP_MULDIV;
        end else if (hit_sys) begin
            info_o.grp = GRP_SYS;
        end else begin
            info_o.grp = GRP_NONE;
        end
        // hits are exclusive, so the masked OR leaves one payload
        info_o.payload = ({DEC_PAYLOAD_W{hit_alu}} & alu) |
                         ({DEC_PAYLOAD_W{hit_bjp}} & bjp) |
                         ({DEC_PAYLOAD_W{hit_mem}} & mem) |
                         ({DEC_PAYLOAD_W{hit_md}}  & md)  |
                         ({DEC_PAYLOAD_W{hit_sys}} & sys);
    end

    // shamt[5] set on RV32 shows up as funct7 = 0000001
    assign slli_bad  = op_imm & f3[1] & f7_muldiv;
    assign illegal_o = (info_o.grp == GRP_NONE) | slli_bad;

endmodule

/* hdl/imm_gen.sv */
// immediate generator
`timescale 1ns/1ps

module imm_gen import rv_decode_pkg::*; (
    input  inst_t           inst_i,
    output logic [XLEN-1:0] imm_o
);

    logic [31:0]     w;
    logic [7:0]      f3;
    logic            op_imm;
    logic            sel_u;
    logic            sel_j;
    logic            sel_jr;
    logic            sel_i;
    logic            sel_b;
    logic            sel_s;
    logic            sel_sh;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_sh;

    assign w      = inst_i;
    assign f3     = 8'b1 << inst_i.funct3;
    assign op_imm = (inst_i.opcode == OPC_OP_IMM);

    // candidate immediates, jalr shares the I format
    assign imm_u  = {w[31:12], 12'b0};
    assign imm_j  = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    assign imm_i  = {{20{w[31]}}, w[31:20]};
    assign imm_b  = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    assign imm_s  = {{20{w[31]}}, w[31:25], w[11:7]};
    assign imm_sh = {27'b0, w[24:20]};

    // format selects are mutually exclusive
    assign sel_u  = (inst_i.opcode == OPC_LUI) | (inst_i.opcode == OPC_AUIPC);
    assign sel_j  = (inst_i.opcode == OPC_JAL);
    assign sel_jr = (inst_i.opcode == OPC_JALR) & f3[0];
    assign sel_i  = (inst_i.opcode == OPC_LOAD) | (op_imm & (f3[0] | f3[2] | f3[3] | f3[4] |
                                                             f3[6] | f3[7]));
    assign sel_b  = (inst_i.opcode == OPC_BRANCH);
    assign sel_s  = (inst_i.opcode == OPC_STORE);
    // shamt forms, srai carries the alternate funct7
    assign sel_sh = op_imm & ((f3[1] & (inst_i.funct7 == F7_BASE)) |
                              (f3[5] & ((inst_i.funct7 == F7_BASE) | (inst_i.funct7 == F7_ALT))));

    assign imm_o = ({XLEN{sel_u}}          & imm_u)  |
                   ({XLEN{sel_j}}          & imm_j)  |
                   ({XLEN{sel_jr | sel_i}} & imm_i)  |
                   ({XLEN{sel_b}}          & imm_b)  |
                   ({XLEN{sel_s}}          & imm_s)  |
                   ({XLEN{sel_sh}}         & imm_sh);

endmodule

/* hdl/rv_decode_pkg.sv */
// RV32IM decode definitions
package rv_decode_pkg;

    localparam int XLEN          = 32;
    localparam int REG_ADDR_W    = 5;
    localparam int DEC_PAYLOAD_W = 16;

    // major opcodes
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    // whole-word encodings, matched exactly
    localparam logic [31:0] INST_NOP    = 32'h0000_0013;
    localparam logic [31:0] INST_ECALL  = 32'h0000_0073;
    localparam logic [31:0] INST_EBREAK = 32'h0010_0073;
    localparam logic [31:0] INST_MRET   = 32'h3020_0073;
    localparam logic [31:0] INST_DRET   = 32'h7b20_0073;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } inst_t;

    typedef enum logic [2:0] {
        GRP_NONE   = 3'd0,
        GRP_ALU    = 3'd1,
        GRP_BJP    = 3'd2,
        GRP_MEM    = 3'd3,
        GRP_MULDIV = 3'd4,
        GRP_SYS    = 3'd5
    } dec_grp_e;

    // each group payload is padded up to DEC_PAYLOAD_W
    typedef struct packed {
        logic [1:0] pad;
        logic lui, auipc, add, sub, sll, slt, sltu;
        logic xor_, srl, sra, or_, and_;
        logic op2imm, op1pc;
    } alu_info_t;

    typedef struct packed {
        logic [7:0] pad;
        logic jump, beq, bne, blt, bge, bltu, bgeu, op1rs1;
    } bjp_info_t;

    typedef struct packed {
        logic [5:0] pad;
        logic lb, lh, lw, lbu, lhu, sb, sh, sw;
        logic op_load, op_store;
    } mem_info_t;

    typedef struct packed {
        logic [5:0] pad;
        logic mul, mulh, mulhsu, mulhu, div, divu, rem, remu;
        logic op_mul, op_div;
    } muldiv_info_t;

    typedef struct packed {
        logic [9:0] pad;
        logic ecall, ebreak, nop, mret, dret, fence;
    } sys_info_t;

    typedef union packed {
        alu_info_t    alu;
        bjp_info_t    bjp;
        mem_info_t    mem;
        muldiv_info_t muldiv;
        sys_info_t    sys;
    } dec_payload_u;

    typedef struct packed {
        dec_grp_e     grp;
        dec_payload_u payload;
    } dec_info_t;

    typedef struct packed {
        logic                  rs1_re;
        logic [REG_ADDR_W-1:0] rs1_addr;
        logic                  rs2_re;
        logic [REG_ADDR_W-1:0] rs2_addr;
        logic                  rd_we;
        logic [REG_ADDR_W-1:0] rd_addr;
    } reg_ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] inst_addr;
        logic [XLEN-1:0] imm;
        dec_info_t       info;
        reg_ctrl_t       regs;
        logic            illegal;
    } dec_out_t;

endpackage
